// ==== include/bpu_consts.svh ====
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// datapath
`define XLEN        32
`define GHIST_LEN   16      // global history bits

// tagged tables
`define TAGE_ENTRIES 256
`define TAGE_IDX_W   8
`define TAG_W        10
`define PTAG_W       6      // top tag bits compared on lookup

// bimodal base table indexed by pc[9:1]
`define BIM_ENTRIES 512
`define BIM_IDX_W   9

// direct mapped branch target buffer
`define BTB_ENTRIES 256
`define BTB_IDX_W   8
`define BTB_TAG_W   22      // pc[31:10]

// rv32 control flow opcodes
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

`endif

// ==== rtl/bpu_pkg.sv ====
`include "bpu_consts.svh"

package bpu_pkg;

    // 2-bit saturating counter whose msb gives the direction
    typedef logic [1:0] ctr_t;

    typedef enum logic [1:0] {
        CLS_NONE   = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JAL    = 2'd2,
        CLS_JALR   = 2'd3
    } inst_class_e;

    // which table gave the direction
    typedef enum logic [1:0] {
        PROV_BIM = 2'd0,
        PROV_T0  = 2'd1,
        PROV_T1  = 2'd2
    } provider_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } fetch_req_t;

    typedef struct packed {
        logic                  is_cf;      // any control flow instruction
        logic                  taken;
        logic [`XLEN-1:0]      next_pc;
        provider_e             provider;
        logic [`GHIST_LEN-1:0] ghist;      // history seen by this lookup
    } bpu_pred_t;

    // resolved outcome from execute with the prediction context carried back
    typedef struct packed {
        logic                  valid;
        inst_class_e           cls;
        logic [`XLEN-1:0]      pc;
        logic [`GHIST_LEN-1:0] ghist;
        provider_e             provider;
        logic                  pred_taken;
        logic                  taken;
        logic [`XLEN-1:0]      target;
    } bpu_update_t;

endpackage

// ==== rtl/bpu_top.sv ====
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_top
    import bpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_req_t            fetch_i,
    input  bpu_update_t           update_i,
    output bpu_pred_t             pred_o,
    output logic [`GHIST_LEN-1:0] history_o
);

    logic [`GHIST_LEN-1:0] ghist_q;
    inst_class_e           cls;
    logic [`XLEN-1:0]      br_imm, jal_imm;
    logic [`XLEN-1:0]      btb_target;
    logic                  btb_hit;
    logic                  dir_taken;
    provider_e             provider;

    // history moves only on resolved outcomes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (update_i.valid) begin
            ghist_q <= {ghist_q[`GHIST_LEN-2:0], update_i.taken};
        end
    end

    assign history_o = ghist_q;

    inst_predecode u_predecode (
        .inst_i    (fetch_i.inst),
        .cls_o     (cls),
        .br_imm_o  (br_imm),
        .jal_imm_o (jal_imm)
    );

    tage_dir_pred u_tage (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (fetch_i.pc),
        .ghist_i    (ghist_q),
        .update_i   (update_i),
        .taken_o    (dir_taken),
        .provider_o (provider)
    );

    branch_target_buffer u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (fetch_i.pc),
        .update_i (update_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    always_comb begin
        pred_o.is_cf    = (cls != CLS_NONE);
        pred_o.provider = provider;
        pred_o.ghist    = ghist_q;   // snapshot goes back with the update
        pred_o.taken    = 1'b0;
        pred_o.next_pc  = fetch_i.pc + `XLEN'd4;
        case (cls)
            CLS_JAL: begin
                pred_o.taken   = 1'b1;
                pred_o.next_pc = btb_hit ? btb_target : fetch_i.pc + jal_imm;
            end
            CLS_BRANCH: begin
                pred_o.taken = dir_taken;
                if (dir_taken) begin
                    pred_o.next_pc = btb_hit ? btb_target : fetch_i.pc + br_imm;
                end
            end
            CLS_JALR: begin
                pred_o.taken = btb_hit;   // no target without the btb
                if (btb_hit) begin
                    pred_o.next_pc = btb_target;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/branch_target_buffer.sv ====
`timescale 1ns/1ps
`include "bpu_consts.svh"

module branch_target_buffer
    import bpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] pc_i,
    input  bpu_update_t      update_i,
    output logic             hit_o,
    output logic [`XLEN-1:0] target_o
);

    typedef struct packed {
        logic                  valid;
        logic [`BTB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      target;
    } btb_entry_t;

    btb_entry_t btb_q [`BTB_ENTRIES];

    logic [`BTB_IDX_W-1:0] rd_idx, wr_idx;
    logic [`BTB_TAG_W-1:0] rd_tag, wr_tag;
    btb_entry_t            rd_entry;
    logic                  wr_en;

    // index pc[9:2], tag pc[31:10]
    assign rd_idx = pc_i[`BTB_IDX_W+1:2];
    assign rd_tag = pc_i[`XLEN-1:`XLEN-`BTB_TAG_W];
    assign wr_idx = update_i.pc[`BTB_IDX_W+1:2];
    assign wr_tag = update_i.pc[`XLEN-1:`XLEN-`BTB_TAG_W];

    assign rd_entry = btb_q[rd_idx];
    assign hit_o    = rd_entry.valid && (rd_entry.tag == rd_tag);
    assign target_o = rd_entry.target;

    // only taken transfers are worth a target
    assign wr_en = update_i.valid && update_i.taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btb_q[i] <= '0;
            end
        end else if (wr_en) begin
            btb_q[wr_idx].valid  <= 1'b1;
            btb_q[wr_idx].tag    <= wr_tag;
            btb_q[wr_idx].target <= update_i.target;   // last seen target wins
        end
    end

endmodule

// ==== rtl/inst_predecode.sv ====
`timescale 1ns/1ps
`include "bpu_consts.svh"

module inst_predecode
    import bpu_pkg::*;
(
    input  logic [`XLEN-1:0] inst_i,
    output inst_class_e      cls_o,
    output logic [`XLEN-1:0] br_imm_o,
    output logic [`XLEN-1:0] jal_imm_o
);

    logic [6:0] opcode;
    logic       sign;

    assign opcode = inst_i[6:0];
    assign sign   = inst_i[31];

    always_comb begin
        case (opcode)
            `OPC_BRANCH: cls_o = CLS_BRANCH;
            `OPC_JAL:    cls_o = CLS_JAL;
            `OPC_JALR:   cls_o = CLS_JALR;
            default:     cls_o = CLS_NONE;
        endcase
    end

    // b-type offset imm[12|10:5|4:1|11]
    assign br_imm_o = {
        {(`XLEN-13){sign}},
        sign,
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // j-type offset imm[20|10:1|11|19:12]
    assign jal_imm_o = {
        {(`XLEN-21){sign}},
        sign,
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

    // jalr target depends on rs1, so nothing to extract for it here

endmodule

// ==== rtl/tage_dir_pred.sv ====
`timescale 1ns/1ps
`include "bpu_consts.svh"

module tage_dir_pred
    import bpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`XLEN-1:0]      pc_i,
    input  logic [`GHIST_LEN-1:0] ghist_i,
    input  bpu_update_t           update_i,
    output logic                  taken_o,
    output provider_e             provider_o
);

    ctr_t              bim_ctr  [`BIM_ENTRIES];
    ctr_t              t0_ctr   [`TAGE_ENTRIES];
    ctr_t              t1_ctr   [`TAGE_ENTRIES];
    logic [`TAG_W-1:0] t0_tag_q [`TAGE_ENTRIES];
    logic [`TAG_W-1:0] t1_tag_q [`TAGE_ENTRIES];

    logic [`BIM_IDX_W-1:0]  bim_idx, bim_idx_u;
    logic [`TAGE_IDX_W-1:0] t0_idx, t1_idx, t0_idx_u, t1_idx_u;
    logic [`TAG_W-1:0]      t0_tag, t1_tag, t0_tag_u, t1_tag_u;
    logic                   t0_hit, t1_hit;
    logic                   br_upd, mispred;

    function automatic logic [`TAGE_IDX_W-1:0] fold_idx(
        input logic [`XLEN-1:0] pc, input logic [`TAGE_IDX_W-1:0] h);
        return pc[`TAGE_IDX_W-1:0] ^ h;
    endfunction

    function automatic logic [`TAG_W-1:0] fold_tag(
        input logic [`XLEN-1:0] pc, input logic [`TAG_W-1:0] h);
        return pc[`TAGE_IDX_W +: `TAG_W] ^ h;   // pc[17:8]
    endfunction

    function automatic ctr_t ctr_step(input ctr_t c, input logic up);
        ctr_t r;
        r = c;
        if (up && c != 2'b11) begin
            r = c + 2'b01;
        end else if (!up && c != 2'b00) begin
            r = c - 2'b01;
        end
        return r;
    endfunction

    // lookup side
    assign bim_idx = pc_i[`BIM_IDX_W:1];
    assign t0_idx  = fold_idx(pc_i, ghist_i[`TAGE_IDX_W-1:0]);
    assign t1_idx  = fold_idx(pc_i, ghist_i[`GHIST_LEN-1:`TAGE_IDX_W]);
    assign t0_tag  = fold_tag(pc_i, ghist_i[`GHIST_LEN-1 -: `TAG_W]);
    assign t1_tag  = fold_tag(pc_i, {{(`TAG_W-`TAGE_IDX_W){1'b0}}, ghist_i[`TAGE_IDX_W-1:0]});

    // partial tag match only
    assign t0_hit = t0_tag_q[t0_idx][`TAG_W-1 -: `PTAG_W] == t0_tag[`TAG_W-1 -: `PTAG_W];
    assign t1_hit = t1_tag_q[t1_idx][`TAG_W-1 -: `PTAG_W] == t1_tag[`TAG_W-1 -: `PTAG_W];

    always_comb begin
        if (t1_hit) begin
            provider_o = PROV_T1;
            taken_o    = t1_ctr[t1_idx][1];
        end else if (t0_hit) begin
            provider_o = PROV_T0;
            taken_o    = t0_ctr[t0_idx][1];
        end else begin
            provider_o = PROV_BIM;
            taken_o    = bim_ctr[bim_idx][1];
        end
    end

    // update side indices rebuilt from the snapshot carried back
    assign bim_idx_u = update_i.pc[`BIM_IDX_W:1];
    assign t0_idx_u  = fold_idx(update_i.pc, update_i.ghist[`TAGE_IDX_W-1:0]);
    assign t1_idx_u  = fold_idx(update_i.pc, update_i.ghist[`GHIST_LEN-1:`TAGE_IDX_W]);
    assign t0_tag_u  = fold_tag(update_i.pc, update_i.ghist[`GHIST_LEN-1 -: `TAG_W]);
    assign t1_tag_u  = fold_tag(update_i.pc,
                                {{(`TAG_W-`TAGE_IDX_W){1'b0}}, update_i.ghist[`TAGE_IDX_W-1:0]});

    assign br_upd  = update_i.valid && (update_i.cls == CLS_BRANCH);
    assign mispred = update_i.pred_taken != update_i.taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BIM_ENTRIES; i++) begin
                bim_ctr[i] <= 2'b01;   // weak not-taken
            end
            for (int i = 0; i < `TAGE_ENTRIES; i++) begin
                t0_ctr[i]   <= 2'b01;
                t1_ctr[i]   <= 2'b01;
                t0_tag_q[i] <= '0;
                t1_tag_q[i] <= '0;
            end
        end else if (br_upd) begin
            bim_ctr[bim_idx_u] <= ctr_step(bim_ctr[bim_idx_u], update_i.taken);
            if (mispred) begin
                case (update_i.provider)
                    PROV_T1: t1_ctr[t1_idx_u] <= update_i.taken ? 2'b11 : 2'b00;
                    PROV_T0: t0_ctr[t0_idx_u] <= update_i.taken ? 2'b11 : 2'b00;
                    PROV_BIM: begin
                        // allocate to the longer history first
                        if (t1_tag_q[t1_idx_u] != t1_tag_u) begin
                            t1_tag_q[t1_idx_u] <= t1_tag_u;
                            t1_ctr[t1_idx_u]   <= update_i.taken ? 2'b10 : 2'b01;
                        end else if (t0_tag_q[t0_idx_u] != t0_tag_u) begin
                            t0_tag_q[t0_idx_u] <= t0_tag_u;
                            t0_ctr[t0_idx_u]   <= update_i.taken ? 2'b10 : 2'b01;
                        end
                    end
                    default: ;
                endcase
            end else begin
                case (update_i.provider)
                    PROV_T1: t1_ctr[t1_idx_u] <= ctr_step(t1_ctr[t1_idx_u], update_i.taken);
                    PROV_T0: t0_ctr[t0_idx_u] <= ctr_step(t0_ctr[t0_idx_u], update_i.taken);
                    default: ;   // bimodal already trained above
                endcase
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module bpu_tb -f sources.f -o bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sources.f ====
+incdir+include
rtl/bpu_pkg.sv
rtl/inst_predecode.sv
rtl/tage_dir_pred.sv
rtl/branch_target_buffer.sv
rtl/bpu_top.sv
tb/clk_gen.sv
tb/bpu_sva.sv
tb/bpu_tb.sv

// ==== tb/bpu_sva.sv ====
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_sva
    import bpu_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input fetch_req_t            fetch_i,
    input bpu_update_t           update_i,
    input bpu_pred_t             pred_i,
    input logic [`GHIST_LEN-1:0] history_i
);

    // resolved outcome enters the history on the edge after the update
    a_hist_shift: assert property (@(posedge clk) disable iff (rst)
        update_i.valid |=> history_i == {$past(history_i[`GHIST_LEN-2:0]), $past(update_i.taken)})
        else $error("history did not shift in the update outcome");

    a_hist_hold: assert property (@(posedge clk) disable iff (rst)
        !update_i.valid |=> history_i == $past(history_i))
        else $error("history changed without a valid update");

    a_seq_pc: assert property (@(posedge clk) disable iff (rst)
        !pred_i.is_cf |-> pred_i.next_pc == fetch_i.pc + `XLEN'd4)
        else $error("next pc is not sequential for a plain instruction");

    a_jal_taken: assert property (@(posedge clk) disable iff (rst)
        fetch_i.inst[6:0] == `OPC_JAL |-> pred_i.taken)
        else $error("jal predicted not taken");

endmodule

// ==== tb/bpu_tb.sv ====
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_tb
    import bpu_pkg::*;
();

    localparam int num_cycles = 2000;
    localparam int rst_cycles = 10;
    localparam int clk_period = 10;

    logic                  clk;
    logic                  rst;
    fetch_req_t            fetch;
    bpu_update_t           upd;
    bpu_pred_t             pred;
    logic [`GHIST_LEN-1:0] history;

    // reference copy of the predictor state
    ctr_t                  m_bim     [`BIM_ENTRIES];
    ctr_t                  m_t0c     [`TAGE_ENTRIES];
    ctr_t                  m_t1c     [`TAGE_ENTRIES];
    logic [`TAG_W-1:0]     m_t0t     [`TAGE_ENTRIES];
    logic [`TAG_W-1:0]     m_t1t     [`TAGE_ENTRIES];
    logic                  m_btb_v   [`BTB_ENTRIES];
    logic [`BTB_TAG_W-1:0] m_btb_tag [`BTB_ENTRIES];
    logic [`XLEN-1:0]      m_btb_tgt [`BTB_ENTRIES];
    logic [`GHIST_LEN-1:0] m_ghist;

    logic [`XLEN-1:0]      pc_tab [16];
    integer                seed;
    int                    errors;
    int                    checks;

    clk_gen #(.period_ns(clk_period)) u_clk (.clk_o(clk));

    bpu_top u_bpu_top (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch),
        .update_i  (upd),
        .pred_o    (pred),
        .history_o (history)
    );

    bind bpu_top bpu_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch_i),
        .update_i  (update_i),
        .pred_i    (pred_o),
        .history_i (history_o)
    );

    function automatic inst_class_e classify(input logic [6:0] opc);
        case (opc)
            `OPC_BRANCH: return CLS_BRANCH;
            `OPC_JAL:    return CLS_JAL;
            `OPC_JALR:   return CLS_JALR;
            default:     return CLS_NONE;
        endcase
    endfunction

    // b-type and j-type offsets straight from the isa encoding
    function automatic logic [31:0] b_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] j_imm(input logic [31:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic ctr_t sat_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    function automatic logic [7:0] tage_index(input logic [31:0] pc, input logic [15:0] gh,
                                              input logic long_hist);
        return long_hist ? pc[7:0] ^ gh[15:8] : pc[7:0] ^ gh[7:0];
    endfunction

    function automatic logic [9:0] tage_tag(input logic [31:0] pc, input logic [15:0] gh,
                                            input logic long_hist);
        return long_hist ? pc[17:8] ^ {2'b00, gh[7:0]} : pc[17:8] ^ gh[15:6];
    endfunction

    task automatic clear_tables();
        for (int i = 0; i < `BIM_ENTRIES; i++) begin
            m_bim[i] = 2'b01;
        end
        for (int i = 0; i < `TAGE_ENTRIES; i++) begin
            m_t0c[i] = 2'b01;
            m_t1c[i] = 2'b01;
            m_t0t[i] = '0;
            m_t1t[i] = '0;
        end
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_btb_v[i] = 1'b0;
        end
        m_ghist = '0;
    endtask

    function automatic bpu_pred_t predict_fetch(input fetch_req_t f);
        bpu_pred_t   p;
        inst_class_e cls;
        logic [7:0]  i0, i1, bt;
        logic [9:0]  g0, g1;
        logic        dir, hit;
        cls = classify(f.inst[6:0]);
        i0  = tage_index(f.pc, m_ghist, 1'b0);
        i1  = tage_index(f.pc, m_ghist, 1'b1);
        g0  = tage_tag(f.pc, m_ghist, 1'b0);
        g1  = tage_tag(f.pc, m_ghist, 1'b1);
        if (m_t1t[i1][9:4] == g1[9:4]) begin   // longest history wins
            p.provider = PROV_T1;
            dir        = m_t1c[i1][1];
        end else if (m_t0t[i0][9:4] == g0[9:4]) begin
            p.provider = PROV_T0;
            dir        = m_t0c[i0][1];
        end else begin
            p.provider = PROV_BIM;
            dir        = m_bim[f.pc[9:1]][1];
        end
        bt        = f.pc[9:2];
        hit       = m_btb_v[bt] && (m_btb_tag[bt] == f.pc[31:10]);
        p.is_cf   = (cls != CLS_NONE);
        p.ghist   = m_ghist;
        p.taken   = 1'b0;
        p.next_pc = f.pc + 32'd4;
        case (cls)
            CLS_JAL: begin
                p.taken   = 1'b1;
                p.next_pc = hit ? m_btb_tgt[bt] : f.pc + j_imm(f.inst);
            end
            CLS_BRANCH: begin
                p.taken = dir;
                if (dir) begin
                    p.next_pc = hit ? m_btb_tgt[bt] : f.pc + b_imm(f.inst);
                end
            end
            CLS_JALR: begin
                p.taken = hit;
                if (hit) begin
                    p.next_pc = m_btb_tgt[bt];
                end
            end
            default: ;
        endcase
        return p;
    endfunction

    task automatic apply_update(input bpu_update_t u);
        logic [7:0] i0, i1, bt;
        logic [9:0] g0, g1;
        logic [8:0] bi;
        if (u.valid) begin
            bi = u.pc[9:1];
            bt = u.pc[9:2];
            i0 = tage_index(u.pc, u.ghist, 1'b0);
            i1 = tage_index(u.pc, u.ghist, 1'b1);
            g0 = tage_tag(u.pc, u.ghist, 1'b0);
            g1 = tage_tag(u.pc, u.ghist, 1'b1);
            m_ghist = {m_ghist[14:0], u.taken};
            if (u.taken) begin
                m_btb_v[bt]   = 1'b1;
                m_btb_tag[bt] = u.pc[31:10];
                m_btb_tgt[bt] = u.target;
            end
            if (u.cls == CLS_BRANCH) begin
                m_bim[bi] = sat_step(m_bim[bi], u.taken);
                if (u.pred_taken != u.taken) begin
                    if (u.provider == PROV_T1) begin
                        m_t1c[i1] = u.taken ? 2'b11 : 2'b00;
                    end else if (u.provider == PROV_T0) begin
                        m_t0c[i0] = u.taken ? 2'b11 : 2'b00;
                    end else if (m_t1t[i1] != g1) begin
                        m_t1t[i1] = g1;
                        m_t1c[i1] = u.taken ? 2'b10 : 2'b01;
                    end else if (m_t0t[i0] != g0) begin
                        m_t0t[i0] = g0;
                        m_t0c[i0] = u.taken ? 2'b10 : 2'b01;
                    end
                end else if (u.provider == PROV_T1) begin
                    m_t1c[i1] = sat_step(m_t1c[i1], u.taken);
                end else if (u.provider == PROV_T0) begin
                    m_t0c[i0] = sat_step(m_t0c[i0], u.taken);
                end
            end
        end
    endtask

    initial begin
        #(2 * (num_cycles + rst_cycles) * clk_period);
        $display("watchdog expired before the stimulus finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        fetch_req_t  prev_fetch;
        bpu_pred_t   exp, prev_pred;
        inst_class_e cls;
        logic [31:0] r;
        seed       = 11;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        fetch      = '0;
        upd        = '0;
        prev_fetch = '0;
        prev_pred  = '0;
        for (int i = 0; i < 16; i++) begin
            pc_tab[i] = 32'h0000_1000 + (i % 4) * 64 + (i / 4) * 4096;   // btb and bim aliases
        end
        clear_tables();
        repeat (rst_cycles) @(posedge clk);
        #1 rst = 1'b0;
        for (int n = 0; n < num_cycles; n++) begin
            @(posedge clk);
            #1;
            apply_update(upd);
            // feedback for last cycle's fetch
            cls = classify(prev_fetch.inst[6:0]);
            r   = $random(seed);
            upd.valid      = (n > 0) && (cls != CLS_NONE) && (r[3:1] != 3'd0);
            upd.cls        = cls;
            upd.pc         = prev_fetch.pc;
            upd.ghist      = prev_pred.ghist;
            upd.provider   = prev_pred.provider;
            upd.pred_taken = prev_pred.taken;
            upd.taken      = (cls == CLS_BRANCH) ? r[0] : 1'b1;
            case (cls)
                CLS_JAL:    upd.target = prev_fetch.pc + j_imm(prev_fetch.inst);
                CLS_BRANCH: upd.target = prev_fetch.pc + b_imm(prev_fetch.inst);
                default:    upd.target = $random(seed);
            endcase
            if (r[7:5] == 3'd0) begin
                upd.target = $random(seed);
            end
            r          = $random(seed);
            fetch.pc   = pc_tab[r[5:2]];
            fetch.inst = $random(seed);
            case (r[1:0])
                2'd0:    fetch.inst[6:0] = 7'b0010011;   // op-imm
                2'd1:    fetch.inst[6:0] = `OPC_BRANCH;
                2'd2:    fetch.inst[6:0] = `OPC_JAL;
                default: fetch.inst[6:0] = `OPC_JALR;
            endcase
            #4;
            exp    = predict_fetch(fetch);
            checks = checks + 6;
            if (pred.is_cf !== exp.is_cf) begin
                $display("FAIL t=%0t pred_o.is_cf got=%b exp=%b", $time, pred.is_cf, exp.is_cf);
                errors++;
            end
            if (pred.taken !== exp.taken) begin
                $display("FAIL t=%0t pred_o.taken got=%b exp=%b", $time, pred.taken, exp.taken);
                errors++;
            end
            if (pred.provider !== exp.provider) begin
                $display("FAIL t=%0t pred_o.provider got=%0d exp=%0d", $time,
                         pred.provider, exp.provider);
                errors++;
            end
            if (pred.next_pc !== exp.next_pc) begin
                $display("FAIL t=%0t pred_o.next_pc got=%h exp=%h", $time,
                         pred.next_pc, exp.next_pc);
                errors++;
            end
            if (pred.ghist !== exp.ghist) begin
                $display("FAIL t=%0t pred_o.ghist got=%h exp=%h", $time, pred.ghist, exp.ghist);
                errors++;
            end
            if (history !== m_ghist) begin
                $display("FAIL t=%0t history_o got=%h exp=%h", $time, history, m_ghist);
                errors++;
            end
            prev_fetch = fetch;
            prev_pred  = exp;
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns = 10
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

endmodule
